// ==== src/cv_settings.svh ====
//----------------------------------------------------------
// Console bus glue memory map and I/O groups
//----------------------------------------------------------
`ifndef CV_SETTINGS_SVH
`define CV_SETTINGS_SVH

//----------------------------------------------------------
// Memory map
//----------------------------------------------------------
// BIOS ROM occupies 0x0000 up to this address
`define CV_BIOS_END       16'h1FFF
// 1 KB work RAM, mirrored across the whole window
`define CV_RAM_BASE       16'h6000
`define CV_RAM_END        16'h7FFF
// Cartridge space runs to the top of memory
`define CV_CART_BASE      16'h8000
// Reads here select the cartridge bank
`define CV_BANK_REG_BASE  16'hFFC0

//----------------------------------------------------------
// I/O port groups, 32 ports each
//----------------------------------------------------------
`define CV_IO_KEY         8'h80
`define CV_IO_VDP         8'hA0
`define CV_IO_JOY         8'hC0
`define CV_IO_PSG         8'hE0

// 10.7 MHz enables per 3.58 MHz cycle
`define CV_CLK_DIV        3

`endif

// ==== src/cv_bus_pkg.sv ====
//----------------------------------------------------------
// CPU bus and memory-side types
//----------------------------------------------------------
package cv_bus_pkg;

  // Z80 address bus
  typedef logic [15:0] cpu_addr_t;

  // One data byte, in either direction
  typedef logic [7:0] cpu_data_t;

  // 8 KB BIOS ROM
  typedef logic [12:0] bios_addr_t;

  // 1 KB RAM, mirrored
  typedef logic [9:0] ram_addr_t;

  // Cartridge bank number, 16 KB per bank
  typedef logic [5:0] cart_page_t;

  // Bank number on top of a 14-bit offset
  typedef logic [19:0] cart_addr_t;

endpackage

// ==== src/cv_timing_pkg.sv ====
//----------------------------------------------------------
// Clock divider types
//----------------------------------------------------------
`include "cv_settings.svh"

package cv_timing_pkg;

  // Divider counts down from phase_n to phase_p
  // The p enable fires in phase_p, the n enable in phase_n
  typedef enum logic [1:0] {
    phase_p   = 2'd0,
    phase_mid = 2'd1,
    phase_n   = 2'(`CV_CLK_DIV - 1)
  } clk_phase_t;

endpackage

// ==== src/cv_cpu_timing.sv ====
//----------------------------------------------------------
// CPU clock enables and M1 wait state
//----------------------------------------------------------
`timescale 1ns/1ns

module cv_cpu_timing (
  input  logic clk_i,
  input  logic reset_n_s,
  input  logic clk_en_10m7_i,
  input  logic m1_n_i,
  input  logic psg_ready_i,
  output logic clk_en_3m58_p_o,
  output logic clk_en_3m58_n_o,
  output logic wait_n_o
);

  cv_timing_pkg::clk_phase_t phase_q;
  logic                      m1_wait_q;

  //----------------------------------------------------------
  // Divide-by-three
  //----------------------------------------------------------
  // Steps only on 10.7 MHz enables, wraps back to phase_n
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      phase_q <= cv_timing_pkg::phase_p;
    end else if (clk_en_10m7_i) begin
      case (phase_q)
        cv_timing_pkg::phase_p:   phase_q <= cv_timing_pkg::phase_n;
        cv_timing_pkg::phase_n:   phase_q <= cv_timing_pkg::phase_mid;
        cv_timing_pkg::phase_mid: phase_q <= cv_timing_pkg::phase_p;
        default:                  phase_q <= cv_timing_pkg::phase_p;
      endcase
    end
  end

  // Enables pass the 10.7 MHz pulse straight through
  // Reset leaves phase_p, so the first pulse lands on p
  assign clk_en_3m58_p_o = clk_en_10m7_i & (phase_q == cv_timing_pkg::phase_p);
  assign clk_en_3m58_n_o = clk_en_10m7_i & (phase_q == cv_timing_pkg::phase_n);

  //----------------------------------------------------------
  // M1 wait flip-flop
  //----------------------------------------------------------
  // One extra T-state per opcode fetch
  // Held clear outside M1, toggles on p enables during M1
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      m1_wait_q <= 1'b0;
    end else if (m1_n_i) begin
      m1_wait_q <= 1'b0;
    end else if (clk_en_3m58_p_o) begin
      m1_wait_q <= ~m1_wait_q;
    end
  end

  // Sound chip busy also stalls the CPU
  assign wait_n_o = psg_ready_i & ~m1_wait_q;

endmodule

// ==== src/cv_addr_decode.sv ====
//----------------------------------------------------------
// Memory and I/O address decoder
//----------------------------------------------------------
`timescale 1ns/1ns
`include "cv_settings.svh"

module cv_addr_decode (
  input  cv_bus_pkg::cpu_addr_t a_i,
  input  logic                  mreq_n_i,
  input  logic                  iorq_n_i,
  input  logic                  rd_n_i,
  input  logic                  wr_n_i,
  input  logic                  m1_n_i,
  input  logic                  rfsh_n_i,
  output logic                  bios_ce_n_o,
  output logic                  ram_ce_n_o,
  output logic                  cart_sel_o,
  output logic                  bank_wr_o,
  output logic                  vdp_r_n_o,
  output logic                  vdp_w_n_o,
  output logic                  psg_we_n_o,
  output logic                  ctrl_r_n_o,
  output logic                  ctrl_en_key_n_o,
  output logic                  ctrl_en_joy_n_o
);

  // Group base bytes, only bits 7..5 decode
  localparam cv_bus_pkg::cpu_data_t io_key_c = `CV_IO_KEY;
  localparam cv_bus_pkg::cpu_data_t io_vdp_c = `CV_IO_VDP;
  localparam cv_bus_pkg::cpu_data_t io_joy_c = `CV_IO_JOY;
  localparam cv_bus_pkg::cpu_data_t io_psg_c = `CV_IO_PSG;

  cv_bus_pkg::cpu_data_t io_port_s;
  logic                  strobe_s;
  logic                  mem_acc_s;
  logic                  mem_rd_s;
  logic                  io_acc_s;
  logic                  io_rd_s;
  logic                  io_wr_s;
  logic                  grp_key_s;
  logic                  grp_vdp_s;
  logic                  grp_joy_s;
  logic                  grp_psg_s;

  //----------------------------------------------------------
  // Cycle type
  //----------------------------------------------------------
  assign strobe_s = ~rd_n_i | ~wr_n_i;

  // Refresh cycles also pull MREQ, keep them out
  assign mem_acc_s = ~mreq_n_i & rfsh_n_i & strobe_s;
  assign mem_rd_s  = ~mreq_n_i & rfsh_n_i & ~rd_n_i;

  // IORQ with M1 low is an interrupt acknowledge
  assign io_acc_s = ~iorq_n_i & m1_n_i & strobe_s;
  assign io_rd_s  = io_acc_s & ~rd_n_i;
  assign io_wr_s  = io_acc_s & ~wr_n_i;

  //----------------------------------------------------------
  // Memory map
  //----------------------------------------------------------
  assign bios_ce_n_o = ~(mem_acc_s & (a_i <= `CV_BIOS_END));
  assign ram_ce_n_o  = ~(mem_acc_s & (a_i >= `CV_RAM_BASE) & (a_i <= `CV_RAM_END));

  // Cartridge is ROM, reads only
  assign cart_sel_o = mem_rd_s & (a_i >= `CV_CART_BASE);

  // Bank switch is a read in the top 64 bytes
  assign bank_wr_o = mem_rd_s & (a_i >= `CV_BANK_REG_BASE);

  //----------------------------------------------------------
  // I/O port groups
  //----------------------------------------------------------
  assign io_port_s = a_i[7:0];

  assign grp_key_s = (io_port_s[7:5] == io_key_c[7:5]);
  assign grp_vdp_s = (io_port_s[7:5] == io_vdp_c[7:5]);
  assign grp_joy_s = (io_port_s[7:5] == io_joy_c[7:5]);
  assign grp_psg_s = (io_port_s[7:5] == io_psg_c[7:5]);

  // Controller mode latches, written only
  assign ctrl_en_key_n_o = ~(io_wr_s & grp_key_s);
  assign ctrl_en_joy_n_o = ~(io_wr_s & grp_joy_s);

  // VDP data or register port by direction
  assign vdp_r_n_o = ~(io_rd_s & grp_vdp_s);
  assign vdp_w_n_o = ~(io_wr_s & grp_vdp_s);

  // Same group: PSG on write, controllers on read
  assign psg_we_n_o = ~(io_wr_s & grp_psg_s);
  assign ctrl_r_n_o = ~(io_rd_s & grp_psg_s);

endmodule

// ==== src/cv_cart_mapper.sv ====
//----------------------------------------------------------
// Cartridge bank mapper
//----------------------------------------------------------
`timescale 1ns/1ns

module cv_cart_mapper (
  input  logic                   clk_i,
  input  logic                   reset_n_s,
  input  cv_bus_pkg::cpu_addr_t  a_i,
  input  logic                   cart_sel_i,
  input  logic                   bank_wr_i,
  input  cv_bus_pkg::cart_page_t cart_pages_i,
  output cv_bus_pkg::cart_addr_t cart_a_o,
  output logic                   cart_en_80_n_o,
  output logic                   cart_en_a0_n_o,
  output logic                   cart_en_c0_n_o,
  output logic                   cart_en_e0_n_o
);

  cv_bus_pkg::cart_page_t bank_q;
  cv_bus_pkg::cart_page_t page_s;
  logic [1:0]             window_s;

  //----------------------------------------------------------
  // Bank register
  //----------------------------------------------------------
  // Bank number comes from the low address bits of the read
  // Masked with the highest bank so it wraps inside the ROM
  always_ff @(posedge clk_i or negedge reset_n_s) begin
    if (!reset_n_s) begin
      bank_q <= '0;
    end else if (bank_wr_i) begin
      bank_q <= a_i[5:0] & cart_pages_i;
    end
  end

  //----------------------------------------------------------
  // Cartridge address
  //----------------------------------------------------------
  // Lower 16 KB is fixed to the last bank
  // Upper 16 KB follows the bank register
  assign page_s = a_i[14] ? bank_q : cart_pages_i;

  assign cart_a_o = {page_s, a_i[13:0]};

  //----------------------------------------------------------
  // 8 KB window enables
  //----------------------------------------------------------
  assign window_s = a_i[14:13];

  // 0x8000, 0xA000, 0xC000, 0xE000
  assign cart_en_80_n_o = ~(cart_sel_i & (window_s == 2'b00));
  assign cart_en_a0_n_o = ~(cart_sel_i & (window_s == 2'b01));
  assign cart_en_c0_n_o = ~(cart_sel_i & (window_s == 2'b10));
  assign cart_en_e0_n_o = ~(cart_sel_i & (window_s == 2'b11));

endmodule

// ==== src/cv_data_mux.sv ====
//----------------------------------------------------------
// CPU read data multiplexer
//----------------------------------------------------------
`timescale 1ns/1ns

module cv_data_mux (
  input  logic                  bios_ce_n_i,
  input  logic                  ram_ce_n_i,
  input  logic                  vdp_r_n_i,
  input  logic                  ctrl_r_n_i,
  input  logic                  cart_sel_i,
  input  cv_bus_pkg::cpu_data_t bios_d_i,
  input  cv_bus_pkg::cpu_data_t ram_d_i,
  input  cv_bus_pkg::cpu_data_t vdp_d_i,
  input  cv_bus_pkg::cpu_data_t ctrl_d_i,
  input  cv_bus_pkg::cpu_data_t cart_d_i,
  output cv_bus_pkg::cpu_data_t d_o
);

  cv_bus_pkg::cpu_data_t bios_m_s;
  cv_bus_pkg::cpu_data_t ram_m_s;
  cv_bus_pkg::cpu_data_t vdp_m_s;
  cv_bus_pkg::cpu_data_t ctrl_m_s;
  cv_bus_pkg::cpu_data_t cart_m_s;

  // Idle sources float high like an open bus
  assign bios_m_s = bios_ce_n_i ? '1 : bios_d_i;
  assign ram_m_s  = ram_ce_n_i  ? '1 : ram_d_i;
  assign vdp_m_s  = vdp_r_n_i   ? '1 : vdp_d_i;
  assign ctrl_m_s = ctrl_r_n_i  ? '1 : ctrl_d_i;
  assign cart_m_s = cart_sel_i  ? cart_d_i : '1;

  // Wired-AND of all sources, 0xFF when nothing drives
  assign d_o = bios_m_s & ram_m_s & vdp_m_s & ctrl_m_s & cart_m_s;

endmodule

// ==== src/cv_bus_glue.sv ====
//----------------------------------------------------------
// Console CPU bus glue top level
//----------------------------------------------------------
`timescale 1ns/1ns

module cv_bus_glue (
  input  logic                   clk_i,
  input  logic                   reset_n_s,
  // CPU bus
  input  cv_bus_pkg::cpu_addr_t  a_i,
  input  logic                   mreq_n_i,
  input  logic                   iorq_n_i,
  input  logic                   rd_n_i,
  input  logic                   wr_n_i,
  input  logic                   m1_n_i,
  input  logic                   rfsh_n_i,
  output cv_bus_pkg::cpu_data_t  cpu_d_o,
  output logic                   wait_n_o,
  // Clocking
  input  logic                   clk_en_10m7_i,
  output logic                   clk_en_3m58_p_o,
  output logic                   clk_en_3m58_n_o,
  // Sound chip
  input  logic                   psg_ready_i,
  output logic                   psg_we_n_o,
  // Video processor
  input  cv_bus_pkg::cpu_data_t  vdp_d_i,
  output logic                   vdp_r_n_o,
  output logic                   vdp_w_n_o,
  // Controllers
  input  cv_bus_pkg::cpu_data_t  ctrl_d_i,
  output logic                   ctrl_r_n_o,
  output logic                   ctrl_en_key_n_o,
  output logic                   ctrl_en_joy_n_o,
  // BIOS ROM
  input  cv_bus_pkg::cpu_data_t  bios_d_i,
  output cv_bus_pkg::bios_addr_t bios_a_o,
  output logic                   bios_ce_n_o,
  // Work RAM
  input  cv_bus_pkg::cpu_data_t  ram_d_i,
  output cv_bus_pkg::ram_addr_t  ram_a_o,
  output logic                   ram_ce_n_o,
  output logic                   ram_we_n_o,
  output logic                   ram_rd_n_o,
  // Cartridge
  input  cv_bus_pkg::cart_page_t cart_pages_i,
  input  cv_bus_pkg::cpu_data_t  cart_d_i,
  output cv_bus_pkg::cart_addr_t cart_a_o,
  output logic                   cart_rd_o,
  output logic                   cart_en_80_n_o,
  output logic                   cart_en_a0_n_o,
  output logic                   cart_en_c0_n_o,
  output logic                   cart_en_e0_n_o
);

  logic cart_sel_s;
  logic bank_wr_s;

  //----------------------------------------------------------
  // Clock enables and wait state
  //----------------------------------------------------------
  cv_cpu_timing timing_i (
    .clk_i           (clk_i),
    .reset_n_s       (reset_n_s),
    .clk_en_10m7_i   (clk_en_10m7_i),
    .m1_n_i          (m1_n_i),
    .psg_ready_i     (psg_ready_i),
    .clk_en_3m58_p_o (clk_en_3m58_p_o),
    .clk_en_3m58_n_o (clk_en_3m58_n_o),
    .wait_n_o        (wait_n_o)
  );

  //----------------------------------------------------------
  // Address decoding
  //----------------------------------------------------------
  cv_addr_decode decode_i (
    .a_i             (a_i),
    .mreq_n_i        (mreq_n_i),
    .iorq_n_i        (iorq_n_i),
    .rd_n_i          (rd_n_i),
    .wr_n_i          (wr_n_i),
    .m1_n_i          (m1_n_i),
    .rfsh_n_i        (rfsh_n_i),
    .bios_ce_n_o     (bios_ce_n_o),
    .ram_ce_n_o      (ram_ce_n_o),
    .cart_sel_o      (cart_sel_s),
    .bank_wr_o       (bank_wr_s),
    .vdp_r_n_o       (vdp_r_n_o),
    .vdp_w_n_o       (vdp_w_n_o),
    .psg_we_n_o      (psg_we_n_o),
    .ctrl_r_n_o      (ctrl_r_n_o),
    .ctrl_en_key_n_o (ctrl_en_key_n_o),
    .ctrl_en_joy_n_o (ctrl_en_joy_n_o)
  );

  // Cartridge bank logic
  cv_cart_mapper mapper_i (
    .clk_i          (clk_i),
    .reset_n_s      (reset_n_s),
    .a_i            (a_i),
    .cart_sel_i     (cart_sel_s),
    .bank_wr_i      (bank_wr_s),
    .cart_pages_i   (cart_pages_i),
    .cart_a_o       (cart_a_o),
    .cart_en_80_n_o (cart_en_80_n_o),
    .cart_en_a0_n_o (cart_en_a0_n_o),
    .cart_en_c0_n_o (cart_en_c0_n_o),
    .cart_en_e0_n_o (cart_en_e0_n_o)
  );

  //----------------------------------------------------------
  // Read data back to the CPU
  //----------------------------------------------------------
  cv_data_mux mux_i (
    .bios_ce_n_i (bios_ce_n_o),
    .ram_ce_n_i  (ram_ce_n_o),
    .vdp_r_n_i   (vdp_r_n_o),
    .ctrl_r_n_i  (ctrl_r_n_o),
    .cart_sel_i  (cart_sel_s),
    .bios_d_i    (bios_d_i),
    .ram_d_i     (ram_d_i),
    .vdp_d_i     (vdp_d_i),
    .ctrl_d_i    (ctrl_d_i),
    .cart_d_i    (cart_d_i),
    .d_o         (cpu_d_o)
  );

  // Memory side addresses, RAM mirrors every 1 KB
  assign bios_a_o = a_i[12:0];
  assign ram_a_o  = a_i[9:0];

  // RAM strobes come straight from the CPU
  assign ram_we_n_o = wr_n_i;
  assign ram_rd_n_o = rd_n_i;

  assign cart_rd_o = cart_sel_s;

endmodule

// ==== bench/cv_bus_glue_tb.sv ====
//----------------------------------------------------------
// Bus glue testbench
//----------------------------------------------------------
`timescale 1ns/1ns
`include "cv_settings.svh"

module cv_bus_glue_tb;

  localparam int clk_period_c   = 4;
  localparam int reset_cycles_c = 10;
  localparam int num_rows_c     = 26;
  // Generous budget per table row, clock and wait tests fit inside it
  localparam int watchdog_ns_c  = (num_rows_c * 20 + reset_cycles_c) * clk_period_c;

  // Strobes as {mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n}
  localparam logic [5:0] st_idle_c    = 6'b111111;
  localparam logic [5:0] st_mem_rd_c  = 6'b010111;
  localparam logic [5:0] st_mem_wr_c  = 6'b011011;
  localparam logic [5:0] st_fetch_c   = 6'b010101;
  localparam logic [5:0] st_rfsh_c    = 6'b010110;
  localparam logic [5:0] st_io_rd_c   = 6'b100111;
  localparam logic [5:0] st_io_wr_c   = 6'b101011;
  localparam logic [5:0] st_int_ack_c = 6'b100101;

  // Bit positions in the select vector, cart_rd is the only active-high one
  localparam logic [3:0] s_bios_c = 4'd12;
  localparam logic [3:0] s_ram_c  = 4'd11;
  localparam logic [3:0] s_cart_c = 4'd10;
  localparam logic [3:0] s_vdpr_c = 4'd9;
  localparam logic [3:0] s_vdpw_c = 4'd8;
  localparam logic [3:0] s_psg_c  = 4'd7;
  localparam logic [3:0] s_ctrl_c = 4'd6;
  localparam logic [3:0] s_key_c  = 4'd5;
  localparam logic [3:0] s_joy_c  = 4'd4;
  localparam logic [3:0] s_e80_c  = 4'd3;
  localparam logic [3:0] s_ea0_c  = 4'd2;
  localparam logic [3:0] s_ec0_c  = 4'd1;
  localparam logic [3:0] s_ee0_c  = 4'd0;
  localparam logic [3:0] s_none_c = 4'hF;
  localparam logic [12:0] sel_idle_c = 13'b1101111111111;

  // Read data source per row
  localparam logic [2:0] src_none_c = 3'd0;
  localparam logic [2:0] src_bios_c = 3'd1;
  localparam logic [2:0] src_ram_c  = 3'd2;
  localparam logic [2:0] src_vdp_c  = 3'd3;
  localparam logic [2:0] src_ctrl_c = 3'd4;
  localparam logic [2:0] src_cart_c = 3'd5;

  localparam cv_bus_pkg::cart_page_t pages_c = 6'h1D;

  logic clk_i;
  logic reset_n_s;
  cv_bus_pkg::cpu_addr_t a_i;
  logic mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i;
  logic clk_en_10m7_i;
  logic psg_ready_i;
  cv_bus_pkg::cart_page_t cart_pages_i;
  cv_bus_pkg::cpu_data_t bios_d_i, ram_d_i, vdp_d_i, ctrl_d_i, cart_d_i;
  cv_bus_pkg::cpu_data_t cpu_d_o;
  logic wait_n_o, clk_en_3m58_p_o, clk_en_3m58_n_o;
  logic psg_we_n_o, vdp_r_n_o, vdp_w_n_o;
  logic ctrl_r_n_o, ctrl_en_key_n_o, ctrl_en_joy_n_o;
  cv_bus_pkg::bios_addr_t bios_a_o;
  cv_bus_pkg::ram_addr_t  ram_a_o;
  logic bios_ce_n_o, ram_ce_n_o, ram_we_n_o, ram_rd_n_o;
  cv_bus_pkg::cart_addr_t cart_a_o;
  logic cart_rd_o, cart_en_80_n_o, cart_en_a0_n_o, cart_en_c0_n_o, cart_en_e0_n_o;

  // Stimulus and expectation table
  string       row_name [num_rows_c];
  logic [15:0] row_addr [num_rows_c];
  logic [5:0]  row_strb [num_rows_c];
  logic [12:0] row_sel  [num_rows_c];
  logic [2:0]  row_src  [num_rows_c];
  logic        row_chk  [num_rows_c];
  logic [19:0] row_cart [num_rows_c];
  int          n_rows;

  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng_state;
  // Reference models of the divider count and the M1 wait flip-flop
  int          div_cnt;
  logic        wait_model;

  cv_bus_glue dut_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic cv_bus_pkg::cpu_data_t next_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  // Idle vector with up to two selects flipped to their active level
  function automatic logic [12:0] active_sels(input logic [3:0] first,
                                              input logic [3:0] second);
    logic [12:0] v;
    v = sel_idle_c;
    if (first <= 4'd12) v[first] = ~v[first];
    if (second <= 4'd12) v[second] = ~v[second];
    return v;
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("Mismatch %s %s: expected 0x%0h actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic report_test(input string test_name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", test_name, err_cnt - errs_before);
    end
  endtask

  task automatic add_row(input string name, input logic [15:0] addr, input logic [5:0] strb,
                         input logic [12:0] sel, input logic [2:0] src,
                         input logic chk, input logic [19:0] cart);
    if (n_rows < num_rows_c) begin
      row_name[n_rows] = name;
      row_addr[n_rows] = addr;
      row_strb[n_rows] = strb;
      row_sel[n_rows]  = sel;
      row_src[n_rows]  = src;
      row_chk[n_rows]  = chk;
      row_cart[n_rows] = cart;
    end
    n_rows++;
  endtask

  //----------------------------------------------------------
  // Table contents
  //----------------------------------------------------------
  // cart_a expectations assume the bank rows run in this order
  task automatic fill_table();
    n_rows = 0;
    add_row("idle_0000", 16'h0000, st_idle_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    add_row("bios_rd_0000", 16'h0000, st_mem_rd_c, active_sels(s_bios_c, s_none_c),
            src_bios_c, 1'b0, 20'h0);
    add_row("bios_rd_1fff", 16'h1FFF, st_mem_rd_c, active_sels(s_bios_c, s_none_c),
            src_bios_c, 1'b0, 20'h0);
    add_row("bios_wr_0abc", 16'h0ABC, st_mem_wr_c, active_sels(s_bios_c, s_none_c),
            src_bios_c, 1'b0, 20'h0);
    add_row("unmapped_2000", 16'h2000, st_mem_rd_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    add_row("unmapped_5fff", 16'h5FFF, st_mem_rd_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    add_row("ram_rd_6000", 16'h6000, st_mem_rd_c, active_sels(s_ram_c, s_none_c),
            src_ram_c, 1'b0, 20'h0);
    add_row("ram_wr_7abc", 16'h7ABC, st_mem_wr_c, active_sels(s_ram_c, s_none_c),
            src_ram_c, 1'b0, 20'h0);
    add_row("ram_rd_7fff", 16'h7FFF, st_mem_rd_c, active_sels(s_ram_c, s_none_c),
            src_ram_c, 1'b0, 20'h0);
    add_row("opfetch_1234", 16'h1234, st_fetch_c, active_sels(s_bios_c, s_none_c),
            src_bios_c, 1'b0, 20'h0);
    add_row("refresh_6100", 16'h6100, st_rfsh_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    // Bank is still 0 here, it latches 5 at the clock edge
    add_row("bank_rd_ffc5", 16'hFFC5, st_mem_rd_c, active_sels(s_cart_c, s_ee0_c),
            src_cart_c, 1'b1, {6'h00, 14'h3FC5});
    add_row("cart_rd_c123", 16'hC123, st_mem_rd_c, active_sels(s_cart_c, s_ec0_c),
            src_cart_c, 1'b1, {6'h05, 14'h0123});
    add_row("cart_rd_8456", 16'h8456, st_mem_rd_c, active_sels(s_cart_c, s_e80_c),
            src_cart_c, 1'b1, {pages_c, 14'h0456});
    add_row("cart_rd_a010", 16'hA010, st_mem_rd_c, active_sels(s_cart_c, s_ea0_c),
            src_cart_c, 1'b1, {pages_c, 14'h2010});
    // 0x3F masked by the page count gives 0x1D
    add_row("bank_rd_ffff", 16'hFFFF, st_mem_rd_c, active_sels(s_cart_c, s_ee0_c),
            src_cart_c, 1'b1, {6'h05, 14'h3FFF});
    add_row("cart_rd_e010", 16'hE010, st_mem_rd_c, active_sels(s_cart_c, s_ee0_c),
            src_cart_c, 1'b1, {6'h1D, 14'h2010});
    add_row("cart_wr_9000", 16'h9000, st_mem_wr_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    add_row("io_wr_key_80", 16'h1280, st_io_wr_c, active_sels(s_key_c, s_none_c),
            src_none_c, 1'b0, 20'h0);
    add_row("io_rd_key_9f", 16'h129F, st_io_rd_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
    add_row("io_rd_vdp_be", 16'h12BE, st_io_rd_c, active_sels(s_vdpr_c, s_none_c),
            src_vdp_c, 1'b0, 20'h0);
    add_row("io_wr_vdp_a1", 16'h34A1, st_io_wr_c, active_sels(s_vdpw_c, s_none_c),
            src_none_c, 1'b0, 20'h0);
    add_row("io_wr_joy_c0", 16'h00C0, st_io_wr_c, active_sels(s_joy_c, s_none_c),
            src_none_c, 1'b0, 20'h0);
    add_row("io_wr_psg_ff", 16'h00FF, st_io_wr_c, active_sels(s_psg_c, s_none_c),
            src_none_c, 1'b0, 20'h0);
    add_row("io_rd_ctrl_e2", 16'h56E2, st_io_rd_c, active_sels(s_ctrl_c, s_none_c),
            src_ctrl_c, 1'b0, 20'h0);
    // Interrupt acknowledge on a VDP port address
    add_row("int_ack_be", 16'h00BE, st_int_ack_c, sel_idle_c, src_none_c, 1'b0, 20'h0);
  endtask

  task automatic apply_row(input int i);
    logic [12:0] act_sel;
    cv_bus_pkg::cpu_data_t exp_d;
    int errs_before;
    errs_before = err_cnt;
    @(negedge clk_i);
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = row_strb[i];
    a_i      = row_addr[i];
    bios_d_i = next_byte();
    ram_d_i  = next_byte();
    vdp_d_i  = next_byte();
    ctrl_d_i = next_byte();
    cart_d_i = next_byte();
    case (row_src[i])
      src_bios_c: exp_d = bios_d_i;
      src_ram_c:  exp_d = ram_d_i;
      src_vdp_c:  exp_d = vdp_d_i;
      src_ctrl_c: exp_d = ctrl_d_i;
      src_cart_c: exp_d = cart_d_i;
      default:    exp_d = 8'hFF;
    endcase
    // Settle time, well before the rising edge
    #1;
    act_sel = {bios_ce_n_o, ram_ce_n_o, cart_rd_o, vdp_r_n_o, vdp_w_n_o, psg_we_n_o,
               ctrl_r_n_o, ctrl_en_key_n_o, ctrl_en_joy_n_o, cart_en_80_n_o,
               cart_en_a0_n_o, cart_en_c0_n_o, cart_en_e0_n_o};
    check_value(row_name[i], "selects", 32'(row_sel[i]), 32'(act_sel));
    check_value(row_name[i], "cpu_d", 32'(exp_d), 32'(cpu_d_o));
    check_value(row_name[i], "bios_a", 32'(row_addr[i][12:0]), 32'(bios_a_o));
    check_value(row_name[i], "ram_a", 32'(row_addr[i][9:0]), 32'(ram_a_o));
    check_value(row_name[i], "ram strobes", 32'({wr_n_i, rd_n_i}),
                32'({ram_we_n_o, ram_rd_n_o}));
    if (row_chk[i]) begin
      check_value(row_name[i], "cart_a", 32'(row_cart[i]), 32'(cart_a_o));
    end
    report_test(row_name[i], errs_before);
  endtask

  //----------------------------------------------------------
  // Clock enable pulses
  //----------------------------------------------------------
  // One 10.7 MHz pulse, then a low cycle and a gap
  task automatic pulse_10m7(input string test_name);
    logic exp_p;
    logic exp_n;
    @(negedge clk_i);
    // M1 high has been seen by at least one edge by now
    if (m1_n_i) wait_model = 1'b0;
    clk_en_10m7_i = 1'b1;
    exp_p = (div_cnt == 0);
    exp_n = (div_cnt == `CV_CLK_DIV - 1);
    #1;
    check_value(test_name, "enable p", 32'(exp_p), 32'(clk_en_3m58_p_o));
    check_value(test_name, "enable n", 32'(exp_n), 32'(clk_en_3m58_n_o));
    // Flip-flop has not moved yet
    check_value(test_name, "wait_n at pulse", 32'(psg_ready_i & ~wait_model), 32'(wait_n_o));
    if (m1_n_i) wait_model = 1'b0;
    else if (exp_p) wait_model = ~wait_model;
    div_cnt = (div_cnt == 0) ? `CV_CLK_DIV - 1 : div_cnt - 1;
    @(negedge clk_i);
    clk_en_10m7_i = 1'b0;
    #1;
    check_value(test_name, "enable p idle", 32'd0, 32'(clk_en_3m58_p_o));
    check_value(test_name, "enable n idle", 32'd0, 32'(clk_en_3m58_n_o));
    check_value(test_name, "wait_n after", 32'(psg_ready_i & ~wait_model), 32'(wait_n_o));
    @(negedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  initial begin
    #(watchdog_ns_c);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns_c);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int errs_before;
    reset_n_s     = 1'b0;
    a_i           = '0;
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = st_idle_c;
    clk_en_10m7_i = 1'b0;
    psg_ready_i   = 1'b1;
    cart_pages_i  = pages_c;
    bios_d_i      = '0;
    ram_d_i       = '0;
    vdp_d_i       = '0;
    ctrl_d_i      = '0;
    cart_d_i      = '0;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    rng_state     = 32'd86;
    div_cnt       = 0;
    wait_model    = 1'b0;
    fill_table();
    if (n_rows != num_rows_c) begin
      err_cnt++;
      $display("Table holds %0d rows but %0d were expected", n_rows, num_rows_c);
    end
    repeat (reset_cycles_c) @(posedge clk_i);
    @(negedge clk_i);
    reset_n_s = 1'b1;

    for (int i = 0; i < num_rows_c; i++) begin
      apply_row(i);
    end
    @(negedge clk_i);
    {mreq_n_i, iorq_n_i, rd_n_i, wr_n_i, m1_n_i, rfsh_n_i} = st_idle_c;

    // p first, n one pulse later, then a quiet pulse
    errs_before = err_cnt;
    repeat (9) pulse_10m7("clk_enables");
    report_test("clk_enables", errs_before);

    // Opcode fetch stretch, toggles on each p enable
    // Ends on a p enable so the flip-flop is left set
    errs_before = err_cnt;
    @(negedge clk_i);
    m1_n_i = 1'b0;
    repeat (7) pulse_10m7("wait_m1_fetch");
    report_test("wait_m1_fetch", errs_before);

    // M1 high clears the set flip-flop without an enable
    errs_before = err_cnt;
    @(negedge clk_i);
    m1_n_i = 1'b1;
    repeat (3) pulse_10m7("wait_m1_high");
    report_test("wait_m1_high", errs_before);

    // Sound chip busy holds the CPU
    errs_before = err_cnt;
    @(negedge clk_i);
    psg_ready_i = 1'b0;
    repeat (3) pulse_10m7("wait_psg_busy");
    psg_ready_i = 1'b1;
    #1;
    check_value("wait_psg_busy", "wait_n released", 32'd1, 32'(wait_n_o));
    report_test("wait_psg_busy", errs_before);

    $display("Summary: %0d tests, %0d failed, %0d mismatches",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
src/cv_bus_pkg.sv
src/cv_timing_pkg.sv
src/cv_cpu_timing.sv
src/cv_addr_decode.sv
src/cv_cart_mapper.sv
src/cv_data_mux.sv
src/cv_bus_glue.sv
bench/cv_bus_glue_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bus glue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=cv_bus_glue_sim
log_file=sim.log

verilator --binary --timing -f files.f --top-module cv_bus_glue_tb \
  -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1
